// ==== src/rtc_defs.svh ====
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

// Register word offsets.
`define RTC_CDR_OFF    4'd0
`define RTC_MR_OFF     4'd1
`define RTC_CLR_OFF    4'd2
`define RTC_CR_OFF     4'd3
`define RTC_STAT_OFF   4'd4
`define RTC_RSTAT_OFF  4'd5
`define RTC_EOI_OFF    4'd6
`define RTC_VID_OFF    4'd7
`define RTC_DIV_OFF    4'd8

// Read-only version ID.
`define RTC_VERSION_ID 32'h3230312a

// Field widths.
`define RTC_WORD_W     32
`define RTC_OFF_W      4
`define RTC_CTRL_W     4
`define RTC_DIV_W      20

// Divider value out of reset.
`define RTC_DIV_RESET  1

`endif

// ==== src/rtc_pkg.sv ====
`default_nettype none

`include "rtc_defs.svh"

package rtc_pkg;

  // Bus data and count value.
  typedef logic [`RTC_WORD_W-1:0] rtc_word_t;

  // Prescaler divider value.
  typedef logic [`RTC_DIV_W-1:0] rtc_div_t;

  // Register word offset.
  typedef logic [`RTC_OFF_W-1:0] rtc_offset_t;

  // Control register in the bit order of CR[3:0].
  typedef struct packed {
    logic wrap_en;
    logic cnt_en;
    logic intr_mask;
    logic intr_en;
  } rtc_ctrl_t;

  // APB request with plain strobes only.
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    rtc_offset_t paddr;
    rtc_word_t   pwdata;
  } apb_req_t;

endpackage

`default_nettype wire

// ==== src/rtc_apb_regs.sv ====
`default_nettype none

`include "rtc_defs.svh"

module rtc_apb_regs
  import rtc_pkg::*;
(
  input  logic      i_rtc_ext_clk,
  input  logic      presetn,
  input  apb_req_t  i_apb,
  input  rtc_word_t i_count,
  input  logic      i_int_flag,
  output rtc_word_t o_prdata,
  output rtc_ctrl_t o_ctrl,
  output rtc_div_t  o_div,
  output rtc_word_t o_match_val,
  output rtc_word_t o_load_val,
  output logic      o_load,
  output logic      o_eoi
);

  logic      access;
  logic      wr_en;
  logic      rd_en;
  logic      wen_mr;
  logic      wen_clr;
  logic      wen_cr;
  logic      wen_div;
  logic      stat;
  rtc_ctrl_t cr_q;
  rtc_word_t mr_q;
  rtc_word_t clr_q;
  rtc_div_t  div_q;
  logic      load_q;

  // Access cycle of a transfer.
  assign access = i_apb.psel && i_apb.penable;
  assign wr_en  = access && i_apb.pwrite;
  assign rd_en  = access && !i_apb.pwrite;

  assign wen_mr  = wr_en && (i_apb.paddr == `RTC_MR_OFF);
  assign wen_clr = wr_en && (i_apb.paddr == `RTC_CLR_OFF);
  assign wen_cr  = wr_en && (i_apb.paddr == `RTC_CR_OFF);
  assign wen_div = wr_en && (i_apb.paddr == `RTC_DIV_OFF);

  // Reading EOI clears the flag.
  assign o_eoi = rd_en && (i_apb.paddr == `RTC_EOI_OFF);

  // Masked status.
  assign stat = i_int_flag && !cr_q.intr_mask;

  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      cr_q <= '0;
    end
    else if (wen_cr)
    begin
      cr_q <= rtc_ctrl_t'(i_apb.pwdata[`RTC_CTRL_W-1:0]);
    end
  end

  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      mr_q <= '0;
    end
    else if (wen_mr)
    begin
      mr_q <= i_apb.pwdata;
    end
  end

  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      div_q <= rtc_div_t'(`RTC_DIV_RESET);
    end
    else if (wen_div)
    begin
      div_q <= i_apb.pwdata[`RTC_DIV_W-1:0];
    end
  end

  // CLR is captured first, then loaded into the counter one cycle later.
  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      clr_q  <= '0;
      load_q <= 1'b0;
    end
    else
    begin
      load_q <= wen_clr;
      if (wen_clr)
      begin
        clr_q <= i_apb.pwdata;
      end
    end
  end

  // Read data is zero outside read access cycles.
  always_comb
  begin
    o_prdata = '0;
    if (rd_en)
    begin
      case (i_apb.paddr)
        `RTC_CDR_OFF:   o_prdata = i_count;
        `RTC_MR_OFF:    o_prdata = mr_q;
        `RTC_CLR_OFF:   o_prdata = clr_q;
        `RTC_CR_OFF:    o_prdata = {{(`RTC_WORD_W-`RTC_CTRL_W){1'b0}}, cr_q};
        `RTC_STAT_OFF:  o_prdata = {{(`RTC_WORD_W-1){1'b0}}, stat};
        `RTC_RSTAT_OFF: o_prdata = {{(`RTC_WORD_W-1){1'b0}}, i_int_flag};
        `RTC_VID_OFF:   o_prdata = `RTC_VERSION_ID;
        `RTC_DIV_OFF:   o_prdata = {{(`RTC_WORD_W-`RTC_DIV_W){1'b0}}, div_q};
        default:        o_prdata = '0;
      endcase
    end
  end

  assign o_ctrl      = cr_q;
  assign o_div       = div_q;
  assign o_match_val = mr_q;
  assign o_load_val  = clr_q;
  assign o_load      = load_q;

endmodule

`default_nettype wire

// ==== src/rtc_prescaler.sv ====
`default_nettype none

module rtc_prescaler
  import rtc_pkg::*;
(
  input  logic     i_rtc_ext_clk,
  input  logic     presetn,
  input  logic     i_cnt_en,
  input  rtc_div_t i_div,
  output logic     o_tick
);

  rtc_div_t div_cnt;
  logic     terminal;

  // Last cycle of a period; also recovers if div drops below the count.
  assign terminal = (div_cnt >= i_div);

  // One tick every div+1 enabled cycles.
  assign o_tick = i_cnt_en && terminal;

  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      div_cnt <= '0;
    end
    else if (i_cnt_en)
    begin
      if (terminal)
      begin
        div_cnt <= '0;
      end
      else
      begin
        div_cnt <= div_cnt + rtc_div_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/rtc_counter.sv ====
`default_nettype none

module rtc_counter
  import rtc_pkg::*;
(
  input  logic      i_rtc_ext_clk,
  input  logic      presetn,
  input  rtc_ctrl_t i_ctrl,
  input  logic      i_tick,
  input  logic      i_load,
  input  rtc_word_t i_load_val,
  input  rtc_word_t i_match_val,
  output rtc_word_t o_count,
  output logic      o_match
);

  rtc_word_t count_q;
  logic      hit;

  // Count equals the match register.
  assign hit = (count_q == i_match_val);

  // Match only counts on a tick.
  assign o_match = i_tick && hit;

  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      count_q <= '0;
    end
    else if (i_load)
    begin
      // Load wins over a tick in the same cycle.
      count_q <= i_load_val;
    end
    else if (i_tick)
    begin
      if (i_ctrl.wrap_en && hit)
      begin
        count_q <= '0;
      end
      else
      begin
        count_q <= count_q + rtc_word_t'(1);
      end
    end
  end

  assign o_count = count_q;

endmodule

`default_nettype wire

// ==== src/rtc_irq_ctrl.sv ====
`default_nettype none

module rtc_irq_ctrl
  import rtc_pkg::*;
(
  input  logic      i_rtc_ext_clk,
  input  logic      presetn,
  input  rtc_ctrl_t i_ctrl,
  input  logic      i_match,
  input  logic      i_eoi,
  output logic      o_int_flag,
  output logic      o_irq
);

  logic flag_q;
  logic set_flag;

  assign set_flag = i_match && i_ctrl.intr_en;

  // Sticky flag; a new match beats an EOI in the same cycle.
  always_ff @(posedge i_rtc_ext_clk or negedge presetn)
  begin
    if (!presetn)
    begin
      flag_q <= 1'b0;
    end
    else if (set_flag)
    begin
      flag_q <= 1'b1;
    end
    else if (i_eoi)
    begin
      flag_q <= 1'b0;
    end
  end

  assign o_int_flag = flag_q;

  // The mask hides only the line and leaves the raw flag as it is.
  assign o_irq = flag_q && !i_ctrl.intr_mask;

endmodule

`default_nettype wire

// ==== src/rtc_top.sv ====
`default_nettype none

module rtc_top
  import rtc_pkg::*;
(
  input  logic      i_rtc_ext_clk,
  input  logic      presetn,
  input  apb_req_t  i_apb,
  output rtc_word_t o_prdata,
  output logic      o_irq
);

  rtc_ctrl_t ctrl;
  rtc_div_t  div;
  rtc_word_t match_val;
  rtc_word_t load_val;
  rtc_word_t count;
  logic      load;
  logic      eoi;
  logic      tick;
  logic      match;
  logic      int_flag;

  rtc_apb_regs u_apb_regs (
    .i_rtc_ext_clk (i_rtc_ext_clk),
    .presetn       (presetn),
    .i_apb         (i_apb),
    .i_count       (count),
    .i_int_flag    (int_flag),
    .o_prdata      (o_prdata),
    .o_ctrl        (ctrl),
    .o_div         (div),
    .o_match_val   (match_val),
    .o_load_val    (load_val),
    .o_load        (load),
    .o_eoi         (eoi)
  );

  rtc_prescaler u_prescaler (
    .i_rtc_ext_clk (i_rtc_ext_clk),
    .presetn       (presetn),
    .i_cnt_en      (ctrl.cnt_en),
    .i_div         (div),
    .o_tick        (tick)
  );

  rtc_counter u_counter (
    .i_rtc_ext_clk (i_rtc_ext_clk),
    .presetn       (presetn),
    .i_ctrl        (ctrl),
    .i_tick        (tick),
    .i_load        (load),
    .i_load_val    (load_val),
    .i_match_val   (match_val),
    .o_count       (count),
    .o_match       (match)
  );

  rtc_irq_ctrl u_irq_ctrl (
    .i_rtc_ext_clk (i_rtc_ext_clk),
    .presetn       (presetn),
    .i_ctrl        (ctrl),
    .i_match       (match),
    .i_eoi         (eoi),
    .o_int_flag    (int_flag),
    .o_irq         (o_irq)
  );

endmodule

`default_nettype wire

// ==== tests/rtc_assertions.sv ====
`default_nettype none

module rtc_assertions
  import rtc_pkg::*;
(
  input logic      i_rtc_ext_clk,
  input logic      presetn,
  input apb_req_t  i_apb,
  input rtc_word_t i_prdata,
  input logic      i_irq,
  input rtc_ctrl_t i_ctrl,
  input logic      i_load,
  input rtc_word_t i_load_val,
  input rtc_word_t i_count
);

  logic read_access;

  assign read_access = i_apb.psel && i_apb.penable && !i_apb.pwrite;

  // Mask hides the interrupt line.
  irq_masked: assert property (@(posedge i_rtc_ext_clk) disable iff (!presetn)
    i_ctrl.intr_mask |-> !i_irq)
    else $error("o_irq is high while intr_mask is set");

  // Read data bus idle outside read access cycles.
  prdata_idle: assert property (@(posedge i_rtc_ext_clk) disable iff (!presetn)
    !read_access |-> (i_prdata == '0))
    else $error("o_prdata is not zero outside a read access cycle");

  // Loaded value shows up one cycle after the strobe.
  load_value: assert property (@(posedge i_rtc_ext_clk) disable iff (!presetn)
    i_load |=> (i_count == $past(i_load_val)))
    else $error("count does not hold the loaded value after a load strobe");

endmodule

bind rtc_top rtc_assertions rtc_assertions_i (
  .i_rtc_ext_clk (i_rtc_ext_clk),
  .presetn       (presetn),
  .i_apb         (i_apb),
  .i_prdata      (o_prdata),
  .i_irq         (o_irq),
  .i_ctrl        (ctrl),
  .i_load        (load),
  .i_load_val    (load_val),
  .i_count       (count)
);

`default_nettype wire

// ==== tests/rtc_tb.sv ====
`default_nettype none

module rtc_tb
  import rtc_pkg::*;
();

  localparam int MAX_OPS       = 64;
  localparam int POLL_TIMEOUT  = 2000;
  localparam int SPREAD_CYCLES = 4;

  // Opcodes of the pattern file.
  localparam rtc_word_t OP_END   = 32'd0;
  localparam rtc_word_t OP_WRITE = 32'd1;
  localparam rtc_word_t OP_READ  = 32'd2;
  localparam rtc_word_t OP_POLL  = 32'd3;
  localparam rtc_word_t OP_IRQ   = 32'd4;

  // Compare modes of a read come from the data column.
  localparam rtc_word_t CMP_EQ   = 32'd0;
  localparam rtc_word_t CMP_PREV = 32'd1;
  localparam rtc_word_t CMP_MAX  = 32'd2;

  logic      clk;
  logic      presetn;
  apb_req_t  apb;
  rtc_word_t prdata;
  logic      irq;
  rtc_word_t last_read;
  logic [31:0] patterns [0:MAX_OPS*5-1];

  rtc_top rtc_top_i (
    .i_rtc_ext_clk (clk),
    .presetn       (presetn),
    .i_apb         (apb),
    .o_prdata      (prdata),
    .o_irq         (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input int test, input string what, input rtc_word_t expected,
                             input rtc_word_t actual);
    assert (actual == expected)
    else
    begin
      $display("error: test %0d %s expected %h actual %h", test, what, expected, actual);
      abort_run();
    end
  endtask

  // Tasks start and end a small delay after a rising edge.
  task automatic apb_write(input rtc_offset_t off, input rtc_word_t data);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b1;
    apb.paddr   = off;
    apb.pwdata  = data;
    @(posedge clk);
    #1 apb.penable = 1'b1;
    @(posedge clk);
    #1 apb = '0;
  endtask

  task automatic apb_read(input rtc_offset_t off, output rtc_word_t data);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
    apb.paddr   = off;
    apb.pwdata  = '0;
    @(posedge clk);
    #1 apb.penable = 1'b1;
    // Mid-cycle sample of the combinational read data.
    #1 data = prdata;
    @(posedge clk);
    #1 apb = '0;
  endtask

  task automatic read_compare(input int test, input rtc_offset_t off, input rtc_word_t mode,
                              input rtc_word_t expected);
    rtc_word_t value;
    rtc_word_t prev;
    prev = last_read;
    if ((mode == CMP_PREV) || (mode == CMP_MAX))
    begin
      // Leave time for a running counter to move between samples.
      repeat (SPREAD_CYCLES) @(posedge clk);
      #1;
    end
    apb_read(off, value);
    last_read = value;
    case (mode)
      CMP_EQ:   check_value(test, "read", expected, value);
      CMP_PREV: check_value(test, "repeated read", prev, value);
      CMP_MAX:
      begin
        assert (value <= expected)
        else
        begin
          $display("error: test %0d read expected at most %h actual %h", test, expected, value);
          abort_run();
        end
      end
      // Capture only.
      default: ;
    endcase
  endtask

  task automatic poll_read(input int test, input rtc_offset_t off, input rtc_word_t expected);
    rtc_word_t value;
    int        cycles;
    cycles = 0;
    apb_read(off, value);
    while ((value != expected) && (cycles < POLL_TIMEOUT))
    begin
      apb_read(off, value);
      cycles += 2;
    end
    last_read = value;
    assert (value == expected)
    else
    begin
      $display("error: test %0d value %h never appeared at offset %0d within %0d cycles",
               test, expected, off, POLL_TIMEOUT);
      abort_run();
    end
  endtask

  initial
  begin
    int        op;
    int        test;
    logic      done;
    rtc_word_t code;
    rtc_word_t off;
    rtc_word_t data;
    rtc_word_t expected;
    presetn   = 1'b0;
    apb       = '0;
    last_read = '0;
    done      = 1'b0;
    op        = 0;
    $readmemh("tests/rtc_patterns.hex", patterns);
    repeat (5) @(posedge clk);
    #1 presetn = 1'b1;
    @(posedge clk);
    #1;
    while (!done && (op < MAX_OPS))
    begin
      test     = int'(patterns[op*5]);
      code     = patterns[op*5+1];
      off      = patterns[op*5+2];
      data     = patterns[op*5+3];
      expected = patterns[op*5+4];
      case (code)
        OP_END:   done = 1'b1;
        OP_WRITE: apb_write(off[3:0], data);
        OP_READ:  read_compare(test, off[3:0], data, expected);
        OP_POLL:  poll_read(test, off[3:0], expected);
        OP_IRQ:   check_value(test, "o_irq", expected, rtc_word_t'(irq));
        default:
        begin
          $display("error: test %0d has an unknown opcode %h", test, code);
          abort_run();
        end
      endcase
      op++;
    end
    if (done)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("error: the pattern file has no end marker");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== tests/rtc_patterns.hex ====
// Columns: test, opcode (0 end, 1 write, 2 read, 3 poll, 4 check o_irq), offset, data, expected.
// For a read, data selects the compare: 0 equal, 1 same as previous read, 2 at most, 3 none.
01 2 7 00000000 3230312a
01 2 8 00000000 00000001
01 2 3 00000000 00000000
01 2 1 00000000 00000000
01 2 0 00000000 00000000
01 2 4 00000000 00000000
01 4 0 00000000 00000000
02 1 1 a5a55a5a 00000000
02 2 1 00000000 a5a55a5a
02 1 2 12345678 00000000
02 2 2 00000000 12345678
02 1 3 fffffff9 00000000
02 2 3 00000000 00000009
02 1 3 00000000 00000000
02 1 8 ffffffff 00000000
02 2 8 00000000 000fffff
02 1 7 00000000 00000000
02 2 7 00000000 3230312a
03 1 8 00000003 00000000
03 1 2 00000064 00000000
03 1 3 00000004 00000000
03 3 0 00000000 00000069
03 1 3 00000000 00000000
03 2 0 00000003 00000000
03 2 0 00000001 00000000
04 1 1 00000006 00000000
04 1 3 0000000c 00000000
04 1 2 00000000 00000000
04 3 0 00000000 00000006
04 3 0 00000000 00000000
04 2 0 00000002 00000006
04 2 0 00000002 00000006
04 2 0 00000002 00000006
04 2 0 00000002 00000006
04 2 0 00000002 00000006
04 2 0 00000002 00000006
05 1 3 0000000d 00000000
05 3 5 00000000 00000001
05 2 4 00000000 00000001
05 4 0 00000000 00000001
05 1 3 0000000f 00000000
05 2 4 00000000 00000000
05 4 0 00000000 00000000
05 2 5 00000000 00000001
05 1 3 00000002 00000000
05 2 6 00000000 00000000
05 2 5 00000000 00000000
05 2 4 00000000 00000000
05 4 0 00000000 00000000
00 0 0 00000000 00000000

// ==== compile.f ====
+incdir+src
src/rtc_pkg.sv
src/rtc_apb_regs.sv
src/rtc_prescaler.sv
src/rtc_counter.sv
src/rtc_irq_ctrl.sv
src/rtc_top.sv
tests/rtc_assertions.sv
tests/rtc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RTC testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rtc_tb -f compile.f -o rtc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rtc_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF "PASS: all tests"; then
  exit 0
fi
exit 1
